// File: adc_front.sv
`timescale 1ns/1ps
`default_nettype none

module adc_front (
  input  wire logic                                                 adc_clk_i,
  input  wire logic                                                 top_rst_i,
  // raw pin words
  input  wire logic [rp_dsp_pkg::ch_num-1:0][rp_dsp_pkg::adc_raw_w-1:0] adc_dat_i,
  // loopback select and source
  input  wire logic [rp_dsp_pkg::ch_num-1:0]                        loop_i,
  input  wire rp_dsp_pkg::smp_t [rp_dsp_pkg::ch_num-1:0]            dac_smp_i,
  // samples toward ADC calibration
  output rp_dsp_pkg::smp_t [rp_dsp_pkg::ch_num-1:0]                 adc_smp_o
);

  import rp_dsp_pkg::*;

  // registered and converted pin samples
  smp_t [ch_num-1:0] adc_q;

  //////////////////////////////////////////////////
  // input register
  //////////////////////////////////////////////////

  // pins 15..2 carry the code, slope is inverted
  // keep msb, flip the rest to get two's complement
  always_ff @(posedge adc_clk_i, posedge top_rst_i) begin
    if (top_rst_i) begin
      adc_q <= '0;
    end else begin
      for (int i = 0; i < ch_num; i++) begin
        adc_q[i] <= {adc_dat_i[i][adc_raw_w-1], ~adc_dat_i[i][adc_raw_w-2:2]};
      end
    end
  end

  // digital loopback
  // calibrated generator sample replaces the pin sample
  always_comb begin
    for (int i = 0; i < ch_num; i++) begin
      adc_smp_o[i] = loop_i[i] ? dac_smp_i[i] : adc_q[i];
    end
  end

endmodule

`default_nettype wire

// File: calib_regs.sv
`timescale 1ns/1ps
`default_nettype none

module calib_regs (
  input  wire logic                                          adc_clk_i,
  input  wire logic                                          top_rst_i,
  // write port
  input  wire logic                                          cfg_we_i,
  input  wire rp_regs_pkg::reg_addr_t                        cfg_addr_i,
  input  wire rp_regs_pkg::reg_data_t                        cfg_wdata_i,
  // calibration values
  output rp_dsp_pkg::gain_t [rp_dsp_pkg::ch_num-1:0] adc_gain_o,
  output rp_dsp_pkg::off_t  [rp_dsp_pkg::ch_num-1:0] adc_off_o,
  output rp_dsp_pkg::gain_t [rp_dsp_pkg::ch_num-1:0] dac_gain_o,
  output rp_dsp_pkg::off_t  [rp_dsp_pkg::ch_num-1:0] dac_off_o,
  // per channel loopback enables
  output logic              [rp_dsp_pkg::ch_num-1:0] loop_o
);

  import rp_dsp_pkg::*;
  import rp_regs_pkg::*;

  //////////////////////////////////////////////////
  // write decode
  //////////////////////////////////////////////////

  // unmapped addresses fall through to default
  always_ff @(posedge adc_clk_i, posedge top_rst_i) begin
    if (top_rst_i) begin
      for (int i = 0; i < ch_num; i++) begin
        adc_gain_o[i] <= gain_t'(gain_rst);
        dac_gain_o[i] <= gain_t'(gain_rst);
        adc_off_o[i]  <= off_t'(off_rst[smp_w-1:0]);
        dac_off_o[i]  <= off_t'(off_rst[smp_w-1:0]);
      end
      loop_o <= loop_rst[ch_num-1:0];
    end else if (cfg_we_i) begin
      case (cfg_addr_i)
        // gains take the full data word
        addr_adc_gain0: adc_gain_o[0] <= gain_t'(cfg_wdata_i);
        addr_adc_gain1: adc_gain_o[1] <= gain_t'(cfg_wdata_i);
        addr_dac_gain0: dac_gain_o[0] <= gain_t'(cfg_wdata_i);
        addr_dac_gain1: dac_gain_o[1] <= gain_t'(cfg_wdata_i);
        // offsets keep the low sample bits only
        addr_adc_off0:  adc_off_o[0]  <= off_t'(cfg_wdata_i[smp_w-1:0]);
        addr_adc_off1:  adc_off_o[1]  <= off_t'(cfg_wdata_i[smp_w-1:0]);
        addr_dac_off0:  dac_off_o[0]  <= off_t'(cfg_wdata_i[smp_w-1:0]);
        addr_dac_off1:  dac_off_o[1]  <= off_t'(cfg_wdata_i[smp_w-1:0]);
        // one bit per channel
        addr_loop:      loop_o        <= cfg_wdata_i[ch_num-1:0];
        default: begin
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: dac_interleave.sv
`timescale 1ns/1ps
`default_nettype none

module dac_interleave (
  input  wire logic                                       adc_clk_i,
  input  wire logic                                       top_rst_i,
  // calibrated generator samples
  input  wire rp_dsp_pkg::smp_t [rp_dsp_pkg::ch_num-1:0]  smp_i,
  // converter side
  output rp_dsp_pkg::code_t                               dac_dat_o,
  output logic                                            dac_sel_o,
  output logic                                            dac_rst_o
);

  import rp_dsp_pkg::*;

  logic  sel_nxt;
  smp_t  pick;
  code_t code;

  //////////////////////////////////////////////////
  // reset stretch and phase
  //////////////////////////////////////////////////

  // held one extra cycle after top reset drops
  always_ff @(posedge adc_clk_i, posedge top_rst_i) begin
    if (top_rst_i) begin
      dac_rst_o <= 1'b1;
    end else begin
      dac_rst_o <= 1'b0;
    end
  end

  // phase frozen low while converter is in reset
  assign sel_nxt = dac_rst_o ? 1'b0 : ~dac_sel_o;

  // high phase carries channel 0
  assign pick = sel_nxt ? smp_i[0] : smp_i[1];
  // back to converter code
  assign code = {pick[smp_w-1], ~pick[smp_w-2:0]};

  // output register, bus is zero during reset
  always_ff @(posedge adc_clk_i, posedge top_rst_i) begin
    if (top_rst_i) begin
      dac_sel_o <= 1'b0;
      dac_dat_o <= '0;
    end else begin
      dac_sel_o <= sel_nxt;
      dac_dat_o <= dac_rst_o ? code_t'(0) : code;
    end
  end

endmodule

`default_nettype wire

// File: linear_cal.sv
`timescale 1ns/1ps
`default_nettype none

module linear_cal (
  input  wire logic                                        adc_clk_i,
  input  wire logic                                        top_rst_i,
  // input stream, one sample per channel per cycle
  input  wire rp_dsp_pkg::smp_t  [rp_dsp_pkg::ch_num-1:0]  smp_i,
  // calibration values
  input  wire rp_dsp_pkg::gain_t [rp_dsp_pkg::ch_num-1:0]  gain_i,
  input  wire rp_dsp_pkg::off_t  [rp_dsp_pkg::ch_num-1:0]  off_i,
  // calibrated output, registered
  output rp_dsp_pkg::smp_t       [rp_dsp_pkg::ch_num-1:0]  smp_o
);

  import rp_dsp_pkg::*;

  logic signed [prod_w-1:0] prod [ch_num];
  logic signed [prod_w-1:0] sum  [ch_num];
  smp_t [ch_num-1:0]        sat;

  //////////////////////////////////////////////////
  // gain, offset and clamp
  //////////////////////////////////////////////////

  always_comb begin
    for (int i = 0; i < ch_num; i++) begin
      // full width product, no overflow possible
      prod[i] = $signed(smp_i[i]) * $signed(gain_i[i]);
      // drop fraction bits, floor toward minus infinity
      sum[i] = (prod[i] >>> gain_frac) + $signed(off_i[i]);
      // clamp into sample range
      if (sum[i] > smp_max) begin
        sat[i] = smp_max;
      end else if (sum[i] < smp_min) begin
        sat[i] = smp_min;
      end else begin
        sat[i] = sum[i][smp_w-1:0];
      end
    end
  end

  // output register
  always_ff @(posedge adc_clk_i, posedge top_rst_i) begin
    if (top_rst_i) begin
      smp_o <= '0;
    end else begin
      smp_o <= sat;
    end
  end

endmodule

`default_nettype wire

// File: rp_analog.f
rp_dsp_pkg.sv
rp_regs_pkg.sv
calib_regs.sv
adc_front.sv
linear_cal.sv
dac_interleave.sv
rp_analog_top.sv
rp_analog_assert.sv
rp_analog_tb.sv

// File: rp_analog_assert.sv
`timescale 1ns/1ps
`default_nettype none

module rp_analog_assert (
  input wire logic              adc_clk_i,
  input wire logic              top_rst_i,
  input wire rp_dsp_pkg::code_t dac_dat_i,
  input wire logic              dac_sel_i,
  input wire logic              dac_rst_i
);

  // phase alternates once the converter leaves reset
  sel_toggle_a: assert property (@(posedge adc_clk_i) disable iff (top_rst_i)
    !dac_rst_i |=> dac_sel_i != $past(dac_sel_i))
    else $error("dac_sel_o held its level for two cycles");

  // bus parked while converter reset is high
  dat_zero_a: assert property (@(posedge adc_clk_i) dac_rst_i |-> dac_dat_i == '0)
    else $error("dac_dat_o not zero during converter reset");

  // stretch is exactly one cycle
  rst_stretch_a: assert property (@(posedge adc_clk_i) $fell(top_rst_i) |=> $fell(dac_rst_i))
    else $error("dac_rst_o did not fall one cycle after top reset");

endmodule

bind dac_interleave rp_analog_assert u_assert (
  .adc_clk_i (adc_clk_i),
  .top_rst_i (top_rst_i),
  .dac_dat_i (dac_dat_o),
  .dac_sel_i (dac_sel_o),
  .dac_rst_i (dac_rst_o)
);

`default_nettype wire

// File: rp_analog_patterns.txt
# W addr data : register write, hex
# S adc0 adc1 gen0 gen1 osc0 osc1 code0 code1 : hex, samples and codes 14 bit
S 0000 FFFC 0000 0000 1FFF 2000 1FFF 1FFF
S 705C 8F9C 01F4 3E0C 03E8 3C18 1E0B 21F3
W 0 2000
W 1 0064
W 2 2000
W 3 FFFD
W F 1234
S 705C 8FA0 01F4 3E0C 0258 3E08 1E0B 21F3
W 0 7FFF
W 1 0000
W 2 7FFF
S 02FC FFFC 01F4 3E0C 1FFF 2000 1E0B 21F3
W 4 2000
W 5 0010
W 6 C000
W 7 FFFF
S 7FFC 7FFC 03E9 0BB8 0000 3FFD 1DFB 2BB8
W 2 4000
W 8 0002
S 7E6C 0000 03E9 0BB8 00C7 3444 1DFB 2BB8

// File: rp_analog_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rp_analog_tb;

  import rp_dsp_pkg::*;
  import rp_regs_pkg::*;

  // DUT inputs
  logic                 adc_clk = 1'b0;
  logic                 top_rst;
  logic [adc_raw_w-1:0] adc_dat0, adc_dat1;
  smp_t                 gen_dat0, gen_dat1;
  logic                 cfg_we;
  reg_addr_t            cfg_addr;
  reg_data_t            cfg_wdata;
  // DUT outputs
  smp_t                 osc_dat0, osc_dat1;
  code_t                dac_dat;
  logic                 dac_sel, dac_rst;

  // pattern file state
  int            fd;
  int            n_read;
  int            n_checks = 0;
  logic [7:0]    kind;
  logic [1023:0] skip_line;
  logic [15:0]   f_addr, f_data;
  logic [15:0]   f_adc0, f_adc1, f_gen0, f_gen1;
  logic [15:0]   exp_osc0, exp_osc1, exp_code0, exp_code1;

  // 100 ns period
  always #50 adc_clk = ~adc_clk;

  rp_analog_top dut0 (
    .adc_clk_i   (adc_clk),
    .top_rst_i   (top_rst),
    .adc_dat0_i  (adc_dat0),
    .adc_dat1_i  (adc_dat1),
    .gen_dat0_i  (gen_dat0),
    .gen_dat1_i  (gen_dat1),
    .cfg_we_i    (cfg_we),
    .cfg_addr_i  (cfg_addr),
    .cfg_wdata_i (cfg_wdata),
    .osc_dat0_o  (osc_dat0),
    .osc_dat1_o  (osc_dat1),
    .dac_dat_o   (dac_dat),
    .dac_sel_o   (dac_sel),
    .dac_rst_o   (dac_rst)
  );

  //////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("CHECKS FAILED");
    $fatal(1, "simulation stopped");
  endtask

  // codes and samples are zero extended to 16 bits and compared as raw bits
  task automatic check_value(input string what, input logic [15:0] got, input logic [15:0] exp);
    n_checks++;
    assert (got == exp) else begin
      abort_run($sformatf("ERROR at %0t ns: %s is 0x%h, expected 0x%h", $time, what, got, exp));
    end
  endtask

  // sel high marks channel 0 on the bus
  task automatic check_dac(input int ch, input logic [15:0] exp);
    int waited;
    waited = 0;
    while (dac_sel != (ch == 0) && waited < 4) begin
      @(negedge adc_clk);
      waited++;
    end
    if (dac_sel != (ch == 0)) begin
      abort_run($sformatf("timeout waiting for the dac_sel_o phase of channel %0d", ch));
    end
    check_value($sformatf("dac_dat_o ch%0d", ch), {2'b00, dac_dat}, exp);
  endtask

  task automatic write_reg(input logic [15:0] addr, input logic [15:0] data);
    @(negedge adc_clk);
    cfg_we = 1'b1;
    cfg_addr = addr[reg_addr_w-1:0];
    cfg_wdata = data;
    @(negedge adc_clk);
    cfg_we = 1'b0;
  endtask

  task automatic apply_samples();
    @(negedge adc_clk);
    adc_dat0 = f_adc0;
    adc_dat1 = f_adc1;
    gen_dat0 = f_gen0[smp_w-1:0];
    gen_dat1 = f_gen1[smp_w-1:0];
    // wait out both register stages with margin
    repeat (4) @(negedge adc_clk);
    check_value("osc_dat0_o", {2'b00, osc_dat0}, exp_osc0);
    check_value("osc_dat1_o", {2'b00, osc_dat1}, exp_osc1);
    check_dac(0, exp_code0);
    check_dac(1, exp_code1);
  endtask

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////

  initial begin
    top_rst = 1'b1;
    adc_dat0 = '0;
    adc_dat1 = '0;
    gen_dat0 = '0;
    gen_dat1 = '0;
    cfg_we = 1'b0;
    cfg_addr = '0;
    cfg_wdata = '0;
    // converter held in reset and bus parked at zero
    @(negedge adc_clk);
    check_value("dac_rst_o", {15'd0, dac_rst}, 16'd1);
    check_value("dac_sel_o", {15'd0, dac_sel}, 16'd0);
    check_value("dac_dat_o", {2'b00, dac_dat}, 16'd0);
    check_value("osc_dat0_o", {2'b00, osc_dat0}, 16'd0);
    check_value("osc_dat1_o", {2'b00, osc_dat1}, 16'd0);
    repeat (2) @(negedge adc_clk);
    top_rst = 1'b0;

    fd = $fopen("rp_analog_patterns.txt", "r");
    if (fd == 0) begin
      abort_run("could not open rp_analog_patterns.txt");
    end
    while (!$feof(fd)) begin
      n_read = $fscanf(fd, "%s", kind);
      if (n_read != 1) break;
      if (kind == "#") begin
        n_read = $fgets(skip_line, fd);
      end else if (kind == "W") begin
        n_read = $fscanf(fd, "%h %h", f_addr, f_data);
        if (n_read != 2) abort_run("a register write row in the pattern file is malformed");
        write_reg(f_addr, f_data);
      end else if (kind == "S") begin
        n_read = $fscanf(fd, "%h %h %h %h %h %h %h %h", f_adc0, f_adc1, f_gen0, f_gen1,
                         exp_osc0, exp_osc1, exp_code0, exp_code1);
        if (n_read != 8) abort_run("a sample row in the pattern file is malformed");
        apply_samples();
      end else begin
        abort_run("the pattern file holds a row of unknown kind");
      end
    end
    $fclose(fd);

    // reset checks alone mean the file gave no sample rows
    if (n_checks > 5) begin
      $display("ALL CHECKS PASSED");
      $finish;
    end else begin
      abort_run("no sample rows were read from the pattern file");
    end
  end

endmodule

`default_nettype wire

// File: rp_analog_top.sv
`timescale 1ns/1ps
`default_nettype none

module rp_analog_top (
  input  wire logic                                  adc_clk_i,
  input  wire logic                                  top_rst_i,
  // ADC pins
  input  wire logic [rp_dsp_pkg::adc_raw_w-1:0]      adc_dat0_i,
  input  wire logic [rp_dsp_pkg::adc_raw_w-1:0]      adc_dat1_i,
  // generator samples
  input  wire rp_dsp_pkg::smp_t                      gen_dat0_i,
  input  wire rp_dsp_pkg::smp_t                      gen_dat1_i,
  // register write port
  input  wire logic                                  cfg_we_i,
  input  wire rp_regs_pkg::reg_addr_t                cfg_addr_i,
  input  wire rp_regs_pkg::reg_data_t                cfg_wdata_i,
  // calibrated ADC samples
  output rp_dsp_pkg::smp_t                           osc_dat0_o,
  output rp_dsp_pkg::smp_t                           osc_dat1_o,
  // DAC pins
  output rp_dsp_pkg::code_t                          dac_dat_o,
  output logic                                       dac_sel_o,
  output logic                                       dac_rst_o
);

  import rp_dsp_pkg::*;

  //////////////////////////////////////////////////
  // channel bundles
  //////////////////////////////////////////////////

  logic [ch_num-1:0][adc_raw_w-1:0] adc_dat;
  smp_t  [ch_num-1:0]               gen_smp;
  smp_t  [ch_num-1:0]               adc_smp;
  smp_t  [ch_num-1:0]               osc_smp;
  smp_t  [ch_num-1:0]               dac_smp;
  // calibration settings
  gain_t [ch_num-1:0]               adc_gain;
  off_t  [ch_num-1:0]               adc_off;
  gain_t [ch_num-1:0]               dac_gain;
  off_t  [ch_num-1:0]               dac_off;
  logic  [ch_num-1:0]               loop;

  assign adc_dat = {adc_dat1_i, adc_dat0_i};
  assign gen_smp = {gen_dat1_i, gen_dat0_i};
  assign osc_dat0_o = osc_smp[0];
  assign osc_dat1_o = osc_smp[1];

  // register bank
  calib_regs u_regs (
    .adc_clk_i   (adc_clk_i),
    .top_rst_i   (top_rst_i),
    .cfg_we_i    (cfg_we_i),
    .cfg_addr_i  (cfg_addr_i),
    .cfg_wdata_i (cfg_wdata_i),
    .adc_gain_o  (adc_gain),
    .adc_off_o   (adc_off),
    .dac_gain_o  (dac_gain),
    .dac_off_o   (dac_off),
    .loop_o      (loop)
  );

  //////////////////////////////////////////////////
  // ADC path
  //////////////////////////////////////////////////

  // loopback source is the DAC calibration output
  adc_front u_adc (
    .adc_clk_i (adc_clk_i),
    .top_rst_i (top_rst_i),
    .adc_dat_i (adc_dat),
    .loop_i    (loop),
    .dac_smp_i (dac_smp),
    .adc_smp_o (adc_smp)
  );

  linear_cal cal_adc (
    .adc_clk_i (adc_clk_i),
    .top_rst_i (top_rst_i),
    .smp_i     (adc_smp),
    .gain_i    (adc_gain),
    .off_i     (adc_off),
    .smp_o     (osc_smp)
  );

  //////////////////////////////////////////////////
  // DAC path
  //////////////////////////////////////////////////

  linear_cal cal_dac (
    .adc_clk_i (adc_clk_i),
    .top_rst_i (top_rst_i),
    .smp_i     (gen_smp),
    .gain_i    (dac_gain),
    .off_i     (dac_off),
    .smp_o     (dac_smp)
  );

  // both channels share one bus
  dac_interleave u_dac (
    .adc_clk_i (adc_clk_i),
    .top_rst_i (top_rst_i),
    .smp_i     (dac_smp),
    .dac_dat_o (dac_dat_o),
    .dac_sel_o (dac_sel_o),
    .dac_rst_o (dac_rst_o)
  );

endmodule

`default_nettype wire

// File: rp_dsp_pkg.sv
`default_nettype none

package rp_dsp_pkg;

  //////////////////////////////////////////////////
  // channels and sample format
  //////////////////////////////////////////////////

  // both analog channels share one datapath
  localparam int unsigned ch_num = 2;
  localparam int unsigned smp_w = 14;
  // ADC pin word, two low bits unconnected on this board
  localparam int unsigned adc_raw_w = 16;

  // signed sample as seen by the calibration stages
  typedef logic signed [smp_w-1:0] smp_t;
  // converter code, offset binary with inverted slope
  typedef logic [smp_w-1:0] code_t;

  //////////////////////////////////////////////////
  // calibration arithmetic
  //////////////////////////////////////////////////

  // gain is Q2.14, so 16384 is unity
  localparam int unsigned gain_w = 16;
  localparam int unsigned gain_frac = 14;
  typedef logic signed [gain_w-1:0] gain_t;
  typedef logic signed [smp_w-1:0] off_t;
  // full product width
  localparam int unsigned prod_w = smp_w + gain_w;

  // clamp limits
  localparam smp_t smp_max = smp_t'(8191);
  localparam smp_t smp_min = smp_t'(-8192);

endpackage

`default_nettype wire

// File: rp_regs_pkg.sv
`default_nettype none

package rp_regs_pkg;

  // write port format
  localparam int unsigned reg_addr_w = 4;
  localparam int unsigned reg_data_w = 16;
  typedef logic [reg_addr_w-1:0] reg_addr_t;
  typedef logic [reg_data_w-1:0] reg_data_t;

  //////////////////////////////////////////////////
  // address map
  //////////////////////////////////////////////////

  localparam reg_addr_t addr_adc_gain0 = 4'd0;
  localparam reg_addr_t addr_adc_off0 = 4'd1;
  localparam reg_addr_t addr_adc_gain1 = 4'd2;
  localparam reg_addr_t addr_adc_off1 = 4'd3;
  localparam reg_addr_t addr_dac_gain0 = 4'd4;
  localparam reg_addr_t addr_dac_off0 = 4'd5;
  localparam reg_addr_t addr_dac_gain1 = 4'd6;
  localparam reg_addr_t addr_dac_off1 = 4'd7;
  // bit i selects loopback on channel i
  localparam reg_addr_t addr_loop = 4'd8;

  // reset values, unity gain and no offset
  localparam reg_data_t gain_rst = 16'd16384;
  localparam reg_data_t off_rst = 16'd0;
  localparam reg_data_t loop_rst = 16'd0;

endpackage

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module rp_analog_tb \
  -f rp_analog.f -o rp_analog_sim

./obj_dir/rp_analog_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "ALL CHECKS PASSED" sim.log; then
  exit 0
else
  exit 1
fi
